// ==== hdl/i2c_pkg.sv ====
package i2c_pkg;

	// Bus framing
	localparam int BYTE_BITS = 8;
	localparam int DEV_ADDR_BITS = 7;

	typedef logic [BYTE_BITS-1:0] byte_t;

	// R/W bit after the device address
	localparam logic BIT_WRITE = 1'b0;
	localparam logic BIT_READ = 1'b1;

	// SDA level in the ninth bit
	localparam logic SDA_ACK = 1'b0;
	localparam logic SDA_NACK = 1'b1;

	// Transaction sequencer states, one-hot
	typedef enum logic [6:0] {
		IDLE  = 7'b0000001,
		DEV_W = 7'b0000010,
		REG   = 7'b0000100,
		WDATA = 7'b0001000,
		DEV_R = 7'b0010000,
		RDATA = 7'b0100000,
		DONE  = 7'b1000000
	} txn_state_t;

endpackage

// ==== hdl/i2c_scl_gen.sv ====
`timescale 1ns/1ps

module i2c_scl_gen #(
	parameter int CLK_FREQ_MHZ = 25,
	parameter int SCL_FREQ_KHZ = 1000
) (
	input  logic i_clk,
	input  logic i_rstn,
	output logic o_scl,
	output logic o_hi_mid,
	output logic o_lo_mid
);

	// System clocks per SCL half period
	localparam int HALF_CNT = CLK_FREQ_MHZ * 500 / SCL_FREQ_KHZ;
	localparam int CNT_W = (HALF_CNT > 1) ? $clog2(HALF_CNT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(HALF_CNT - 1);
	localparam logic [CNT_W-1:0] CNT_MID = CNT_W'(HALF_CNT / 2);

	logic [CNT_W-1:0] half_cnt;

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			half_cnt <= '0;
			o_scl <= 1'b1;
		end else if (half_cnt == CNT_LAST) begin
			half_cnt <= '0;
			o_scl <= ~o_scl;
		end else begin
			half_cnt <= half_cnt + CNT_W'(1);
		end
	end

	// SDA is sampled mid-high and changed mid-low
	assign o_hi_mid = o_scl && (half_cnt == CNT_MID);
	assign o_lo_mid = !o_scl && (half_cnt == CNT_MID);

endmodule

// ==== hdl/i2c_byte_tx.sv ====
`timescale 1ns/1ps

module i2c_byte_tx (
	input  logic           i_clk,
	input  logic           i_rstn,
	input  logic           i_hi_mid,
	input  logic           i_lo_mid,
	input  logic           i_req,
	input  logic           i_start,
	input  logic           i_stop,
	input  i2c_pkg::byte_t i_data,
	input  logic           i_sda,
	output logic           o_done,
	output logic           o_nack,
	output logic           o_sda,
	output logic           o_sda_oe
);

	localparam int CNT_W = $clog2(i2c_pkg::BYTE_BITS + 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(i2c_pkg::BYTE_BITS);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_ACK,
		ST_STOP,
		ST_END
	} state_t;

	state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic phase;
	logic stop_q;
	i2c_pkg::byte_t shreg;

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			phase <= 1'b0;
			stop_q <= 1'b0;
			o_nack <= 1'b0;
			o_sda <= 1'b1;
			o_sda_oe <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					o_sda <= 1'b1;
					o_sda_oe <= 1'b0;
					bit_cnt <= '0;
					phase <= 1'b0;
					if (i_req) begin
						stop_q <= i_stop;
						o_nack <= 1'b0;
						state <= i_start ? ST_START : ST_DATA;
					end
				end
				// Raise SDA while SCL is low, then pull it low while SCL is high
				ST_START: begin
					if (i_lo_mid) begin
						o_sda <= 1'b1;
						o_sda_oe <= 1'b1;
						phase <= 1'b1;
					end else if (i_hi_mid && phase) begin
						o_sda <= 1'b0;
						phase <= 1'b0;
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (i_lo_mid && bit_cnt == CNT_FULL) begin
						o_sda <= 1'b1;
						o_sda_oe <= 1'b0;
						state <= ST_ACK;
					end else if (i_lo_mid) begin
						o_sda <= shreg[i2c_pkg::BYTE_BITS-1];
						o_sda_oe <= 1'b1;
						bit_cnt <= bit_cnt + CNT_W'(1);
					end
				end
				ST_ACK: begin
					if (i_hi_mid) begin
						o_nack <= (i_sda == i2c_pkg::SDA_NACK);
						if (i_sda == i2c_pkg::SDA_NACK || stop_q) begin
							state <= ST_STOP;
						end else begin
							state <= ST_END;
						end
					end
				end
				// SDA low under SCL low, released high under SCL high
				ST_STOP: begin
					if (i_lo_mid) begin
						o_sda <= 1'b0;
						o_sda_oe <= 1'b1;
						phase <= 1'b1;
					end else if (i_hi_mid && phase) begin
						o_sda <= 1'b1;
						phase <= 1'b0;
						state <= ST_END;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// MSB first
	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && i_req) begin
			shreg <= i_data;
		end else if (state == ST_DATA && i_lo_mid) begin
			shreg <= {shreg[i2c_pkg::BYTE_BITS-2:0], 1'b0};
		end
	end

	assign o_done = (state == ST_END);

endmodule

// ==== hdl/i2c_byte_rx.sv ====
`timescale 1ns/1ps

module i2c_byte_rx (
	input  logic           i_clk,
	input  logic           i_rstn,
	input  logic           i_hi_mid,
	input  logic           i_lo_mid,
	input  logic           i_req,
	input  logic           i_last,
	input  logic           i_sda,
	output logic           o_done,
	output i2c_pkg::byte_t o_data,
	output logic           o_sda,
	output logic           o_sda_oe
);

	localparam int CNT_W = $clog2(i2c_pkg::BYTE_BITS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(i2c_pkg::BYTE_BITS - 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DATA,
		ST_ACK,
		ST_STOP,
		ST_END
	} state_t;

	state_t state;
	logic [CNT_W-1:0] bit_cnt;
	logic phase;
	logic last_q;

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state <= ST_IDLE;
			bit_cnt <= '0;
			phase <= 1'b0;
			last_q <= 1'b0;
			o_sda <= 1'b1;
			o_sda_oe <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					o_sda <= 1'b1;
					o_sda_oe <= 1'b0;
					bit_cnt <= '0;
					phase <= 1'b0;
					if (i_req) begin
						last_q <= i_last;
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (i_hi_mid) begin
						bit_cnt <= bit_cnt + CNT_W'(1);
						if (bit_cnt == CNT_LAST) begin
							state <= ST_ACK;
						end
					end
				end
				// Drive the ninth bit for one full SCL period
				ST_ACK: begin
					if (i_lo_mid && !phase) begin
						o_sda <= last_q ? i2c_pkg::SDA_NACK : i2c_pkg::SDA_ACK;
						o_sda_oe <= 1'b1;
						phase <= 1'b1;
					end else if (i_lo_mid && last_q) begin
						o_sda <= 1'b0;
						phase <= 1'b0;
						state <= ST_STOP;
					end else if (i_lo_mid) begin
						o_sda <= 1'b1;
						o_sda_oe <= 1'b0;
						state <= ST_END;
					end
				end
				ST_STOP: begin
					if (i_hi_mid) begin
						o_sda <= 1'b1;
						state <= ST_END;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == ST_DATA && i_hi_mid) begin
			o_data <= {o_data[i2c_pkg::BYTE_BITS-2:0], i_sda};
		end
	end

	assign o_done = (state == ST_END);

endmodule

// ==== hdl/i2c_txn_ctrl.sv ====
`timescale 1ns/1ps

module i2c_txn_ctrl (
	input  logic                              i_clk,
	input  logic                              i_rstn,
	input  logic                              i_wr_req,
	input  logic                              i_rd_req,
	input  logic [i2c_pkg::DEV_ADDR_BITS-1:0] i_dev_addr,
	input  i2c_pkg::byte_t                    i_reg_addr,
	input  i2c_pkg::byte_t                    i_wdata,
	input  logic                              i_wlast,
	input  logic                              i_rlast,
	input  logic                              i_tx_done,
	input  logic                              i_tx_nack,
	input  logic                              i_rx_done,
	input  i2c_pkg::byte_t                    i_rx_data,
	output logic                              o_tx_req,
	output logic                              o_tx_start,
	output logic                              o_tx_stop,
	output i2c_pkg::byte_t                    o_tx_data,
	output logic                              o_rx_req,
	output logic                              o_rx_last,
	output logic                              o_wready,
	output i2c_pkg::byte_t                    o_rdata,
	output logic                              o_rvalid,
	output logic                              o_busy,
	output logic                              o_ack_err
);

	i2c_pkg::txn_state_t state;
	logic is_rd;
	// Request the byte of the current state on the next cycle
	logic issue;

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			state <= i2c_pkg::IDLE;
			is_rd <= 1'b0;
			issue <= 1'b0;
			o_tx_req <= 1'b0;
			o_tx_start <= 1'b0;
			o_tx_stop <= 1'b0;
			o_rx_req <= 1'b0;
			o_rx_last <= 1'b0;
			o_wready <= 1'b0;
			o_rvalid <= 1'b0;
			o_busy <= 1'b0;
			o_ack_err <= 1'b0;
		end else begin
			issue <= 1'b0;
			o_tx_req <= 1'b0;
			o_rx_req <= 1'b0;
			o_wready <= 1'b0;
			o_rvalid <= 1'b0;
			if (issue && state == i2c_pkg::RDATA) begin
				o_rx_req <= 1'b1;
				o_rx_last <= i_rlast;
			end else if (issue) begin
				o_tx_req <= 1'b1;
				o_tx_start <= (state == i2c_pkg::DEV_W) || (state == i2c_pkg::DEV_R);
				o_tx_stop <= (state == i2c_pkg::WDATA) && i_wlast;
			end
			// The transmitter has already sent STOP after a NACK
			if (i_tx_done && i_tx_nack) begin
				state <= i2c_pkg::DONE;
			end else begin
				case (state)
					i2c_pkg::IDLE: begin
						if (i_wr_req || i_rd_req) begin
							is_rd <= !i_wr_req;
							o_busy <= 1'b1;
							o_ack_err <= 1'b0;
							issue <= 1'b1;
							state <= i2c_pkg::DEV_W;
						end
					end
					i2c_pkg::DEV_W: begin
						if (i_tx_done) begin
							issue <= 1'b1;
							state <= i2c_pkg::REG;
						end
					end
					i2c_pkg::REG: begin
						if (i_tx_done && is_rd) begin
							issue <= 1'b1;
							state <= i2c_pkg::DEV_R;
						end else if (i_tx_done) begin
							issue <= 1'b1;
							state <= i2c_pkg::WDATA;
						end
					end
					// Next byte is taken once the host has seen wready
					i2c_pkg::WDATA: begin
						if (i_tx_done) begin
							o_wready <= 1'b1;
							if (o_tx_stop) begin
								state <= i2c_pkg::DONE;
							end
						end else if (o_wready) begin
							issue <= 1'b1;
						end
					end
					i2c_pkg::DEV_R: begin
						if (i_tx_done) begin
							issue <= 1'b1;
							state <= i2c_pkg::RDATA;
						end
					end
					// Host updates rlast after each rvalid
					i2c_pkg::RDATA: begin
						if (i_rx_done) begin
							o_rvalid <= 1'b1;
							if (o_rx_last) begin
								state <= i2c_pkg::DONE;
							end
						end else if (o_rvalid) begin
							issue <= 1'b1;
						end
					end
					i2c_pkg::DONE: begin
						o_busy <= 1'b0;
						// Transmitter keeps the ACK result of the last byte it sent
						o_ack_err <= i_tx_nack;
						state <= i2c_pkg::IDLE;
					end
					default: begin
						state <= i2c_pkg::IDLE;
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (issue) begin
			case (state)
				i2c_pkg::DEV_W: o_tx_data <= {i_dev_addr, i2c_pkg::BIT_WRITE};
				i2c_pkg::DEV_R: o_tx_data <= {i_dev_addr, i2c_pkg::BIT_READ};
				i2c_pkg::REG:   o_tx_data <= i_reg_addr;
				default:        o_tx_data <= i_wdata;
			endcase
		end
		if (i_rx_done) begin
			o_rdata <= i_rx_data;
		end
	end

endmodule

// ==== hdl/i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master #(
	parameter int CLK_FREQ_MHZ = 25,
	parameter int SCL_FREQ_KHZ = 1000
) (
	input  logic                              i_clk,
	input  logic                              i_rstn,
	input  logic                              i_wr_req,
	input  logic                              i_rd_req,
	input  logic [i2c_pkg::DEV_ADDR_BITS-1:0] i_dev_addr,
	input  i2c_pkg::byte_t                    i_reg_addr,
	input  i2c_pkg::byte_t                    i_wdata,
	input  logic                              i_wlast,
	input  logic                              i_rlast,
	input  logic                              i_sda,
	output logic                              o_wready,
	output i2c_pkg::byte_t                    o_rdata,
	output logic                              o_rvalid,
	output logic                              o_busy,
	output logic                              o_ack_err,
	output logic                              o_scl,
	output logic                              o_sda,
	output logic                              o_sda_oe
);

	logic hi_mid;
	logic lo_mid;
	logic tx_req;
	logic tx_start;
	logic tx_stop;
	logic tx_done;
	logic tx_nack;
	logic tx_sda;
	logic tx_oe;
	logic rx_req;
	logic rx_last;
	logic rx_done;
	logic rx_sda;
	logic rx_oe;
	i2c_pkg::byte_t tx_data;
	i2c_pkg::byte_t rx_data;

	i2c_scl_gen #(
		.CLK_FREQ_MHZ(CLK_FREQ_MHZ),
		.SCL_FREQ_KHZ(SCL_FREQ_KHZ)
	) u_scl_gen (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.o_scl(o_scl), .o_hi_mid(hi_mid), .o_lo_mid(lo_mid)
	);

	i2c_txn_ctrl u_txn_ctrl (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_wr_req(i_wr_req), .i_rd_req(i_rd_req),
		.i_dev_addr(i_dev_addr), .i_reg_addr(i_reg_addr),
		.i_wdata(i_wdata), .i_wlast(i_wlast), .i_rlast(i_rlast),
		.i_tx_done(tx_done), .i_tx_nack(tx_nack),
		.i_rx_done(rx_done), .i_rx_data(rx_data),
		.o_tx_req(tx_req), .o_tx_start(tx_start), .o_tx_stop(tx_stop),
		.o_tx_data(tx_data), .o_rx_req(rx_req), .o_rx_last(rx_last),
		.o_wready(o_wready), .o_rdata(o_rdata), .o_rvalid(o_rvalid),
		.o_busy(o_busy), .o_ack_err(o_ack_err)
	);

	i2c_byte_tx u_byte_tx (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_hi_mid(hi_mid), .i_lo_mid(lo_mid),
		.i_req(tx_req), .i_start(tx_start), .i_stop(tx_stop),
		.i_data(tx_data), .i_sda(i_sda),
		.o_done(tx_done), .o_nack(tx_nack),
		.o_sda(tx_sda), .o_sda_oe(tx_oe)
	);

	i2c_byte_rx u_byte_rx (
		.i_clk(i_clk), .i_rstn(i_rstn),
		.i_hi_mid(hi_mid), .i_lo_mid(lo_mid),
		.i_req(rx_req), .i_last(rx_last), .i_sda(i_sda),
		.o_done(rx_done), .o_data(rx_data),
		.o_sda(rx_sda), .o_sda_oe(rx_oe)
	);

	// Idle engine sits released with SDA high
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			o_sda <= 1'b1;
			o_sda_oe <= 1'b0;
		end else begin
			o_sda <= tx_sda & rx_sda;
			o_sda_oe <= tx_oe | rx_oe;
		end
	end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic o_clk,
	output logic o_rstn
);

	// 40 ns period
	initial begin
		o_clk = 1'b0;
		forever begin
			#20 o_clk = ~o_clk;
		end
	end

	// Reset held for 5 cycles, released just after an edge
	initial begin
		o_rstn = 1'b0;
		repeat (5) @(posedge o_clk);
		#1;
		o_rstn = 1'b1;
	end

endmodule

// ==== dv/i2c_slave_bfm.sv ====
`timescale 1ns/1ps

module i2c_slave_bfm #(
	parameter logic [6:0] DEV_ADDR = 7'h50
) (
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda,
	output int   o_rd_acks,
	output int   o_rd_nacks
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_REG,
		S_WDATA,
		S_RDATA
	} state_t;

	// Register file, filled by the testbench
	logic [7:0] mem [0:255];
	logic [7:0] ptr;
	logic [7:0] shreg;
	logic mst_ack;
	state_t state;
	state_t next_state;
	int bit_cnt;

	initial begin
		o_sda = 1'b1;
		o_rd_acks = 0;
		o_rd_nacks = 0;
		state = S_IDLE;
		next_state = S_IDLE;
		bit_cnt = 0;
		ptr = '0;
		mst_ack = 1'b0;
	end

	// START or repeated START
	always @(negedge i_sda) begin
		if (i_scl === 1'b1) begin
			state = S_ADDR;
			bit_cnt = 0;
			o_sda = 1'b1;
			o_rd_acks = 0;
			o_rd_nacks = 0;
		end
	end

	// STOP
	always @(posedge i_sda) begin
		if (i_scl === 1'b1) begin
			state = S_IDLE;
			o_sda = 1'b1;
		end
	end

	always @(posedge i_scl) begin
		if (state == S_RDATA && bit_cnt == 8) begin
			mst_ack = (i_sda === 1'b0);
			if (mst_ack) begin
				o_rd_acks++;
			end else begin
				o_rd_nacks++;
			end
			bit_cnt = 9;
		end else if (state == S_RDATA) begin
			bit_cnt++;
		end else if (state != S_IDLE && bit_cnt == 8) begin
			bit_cnt = 9;
		end else if (state != S_IDLE) begin
			shreg = {shreg[6:0], i_sda};
			bit_cnt++;
		end
	end

	// SDA only moves well inside SCL low
	always @(negedge i_scl) begin
		#5;
		case (state)
			S_ADDR, S_REG, S_WDATA: begin
				if (bit_cnt == 8 && state == S_ADDR && shreg[7:1] != DEV_ADDR) begin
					// Not our address, stay off the bus
					state = S_IDLE;
				end else if (bit_cnt == 8) begin
					o_sda = 1'b0;
					if (state == S_ADDR) begin
						next_state = shreg[0] ? S_RDATA : S_REG;
					end else if (state == S_REG) begin
						ptr = shreg;
						next_state = S_WDATA;
					end else begin
						mem[ptr] = shreg;
						ptr++;
						next_state = S_WDATA;
					end
				end else if (bit_cnt == 9) begin
					o_sda = 1'b1;
					bit_cnt = 0;
					state = next_state;
					if (state == S_RDATA) begin
						shreg = mem[ptr];
						ptr++;
						o_sda = shreg[7];
					end
				end
			end
			S_RDATA: begin
				if (bit_cnt < 8) begin
					o_sda = shreg[7 - bit_cnt];
				end else if (bit_cnt == 8) begin
					o_sda = 1'b1;
				end else if (mst_ack) begin
					shreg = mem[ptr];
					ptr++;
					bit_cnt = 0;
					o_sda = shreg[7];
				end else begin
					o_sda = 1'b1;
					state = S_IDLE;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// ==== dv/tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master;

	localparam int CLK_FREQ_MHZ = 25;
	localparam int SCL_FREQ_KHZ = 1000;
	localparam logic [6:0] SLAVE_ADDR = 7'h50;
	localparam logic [6:0] BAD_ADDR = 7'h2B;
	// 12 transactions, up to 10 bytes each, about 260 cycles per byte
	localparam int MAX_CYCLES = 60000;

	logic clk;
	logic rstn;
	logic i_wr_req;
	logic i_rd_req;
	logic [6:0] i_dev_addr;
	i2c_pkg::byte_t i_reg_addr;
	i2c_pkg::byte_t i_wdata;
	logic i_wlast;
	logic i_rlast;
	logic o_wready;
	i2c_pkg::byte_t o_rdata;
	logic o_rvalid;
	logic o_busy;
	logic o_ack_err;
	logic o_scl;
	logic o_sda;
	logic o_sda_oe;
	logic slv_sda;
	logic sda_bus;
	int rd_acks;
	int rd_nacks;

	i2c_pkg::byte_t ref_mem [0:255];
	i2c_pkg::byte_t wbuf [0:7];
	logic [31:0] rng_state;
	int cycles = 0;

	tb_clk_gen u_clk_gen (
		.o_clk(clk),
		.o_rstn(rstn)
	);

	i2c_master #(
		.CLK_FREQ_MHZ(CLK_FREQ_MHZ),
		.SCL_FREQ_KHZ(SCL_FREQ_KHZ)
	) i_i2c_master (
		.i_clk(clk), .i_rstn(rstn),
		.i_wr_req(i_wr_req), .i_rd_req(i_rd_req),
		.i_dev_addr(i_dev_addr), .i_reg_addr(i_reg_addr),
		.i_wdata(i_wdata), .i_wlast(i_wlast), .i_rlast(i_rlast),
		.i_sda(sda_bus),
		.o_wready(o_wready), .o_rdata(o_rdata), .o_rvalid(o_rvalid),
		.o_busy(o_busy), .o_ack_err(o_ack_err),
		.o_scl(o_scl), .o_sda(o_sda), .o_sda_oe(o_sda_oe)
	);

	i2c_slave_bfm #(
		.DEV_ADDR(SLAVE_ADDR)
	) u_slave_bfm (
		.i_scl(o_scl),
		.i_sda(sda_bus),
		.o_sda(slv_sda),
		.o_rd_acks(rd_acks),
		.o_rd_nacks(rd_nacks)
	);

	// Open-drain wired AND
	assign sda_bus = (o_sda_oe ? o_sda : 1'b1) & slv_sda;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("test failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		return int'((lcg_next() >> 8) % n);
	endfunction

	function automatic i2c_pkg::byte_t fill_byte(input int a);
		return i2c_pkg::byte_t'((a * 29) ^ (a >> 3) ^ 8'h5C);
	endfunction

	task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s: got %0h, expected %0h",
				$time, what, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic compare_memory();
		for (int a = 0; a < 256; a++) begin
			check_equal(u_slave_bfm.mem[a], ref_mem[a], $sformatf("slave memory at %02h", a));
		end
	endtask

	task automatic write_txn(input logic [6:0] dev, input i2c_pkg::byte_t reg_addr,
			input int n, input logic exp_err);
		int taken;
		taken = 0;
		i_dev_addr = dev;
		i_reg_addr = reg_addr;
		i_wdata = wbuf[0];
		i_wlast = (n == 1);
		i_wr_req = 1'b1;
		@(posedge clk);
		#1;
		i_wr_req = 1'b0;
		check_equal(o_busy, 1'b1, "o_busy after write request");
		check_equal(o_ack_err, 1'b0, "o_ack_err cleared by write request");
		while (o_busy) begin
			@(posedge clk);
			#1;
			check_equal(o_rvalid, 1'b0, "o_rvalid during write");
			if (o_wready) begin
				taken++;
				// Next byte goes out right after wready
				if (taken < n) begin
					i_wdata = wbuf[taken];
					i_wlast = (taken == n - 1);
				end
			end
		end
		check_equal(o_ack_err, exp_err, "o_ack_err at end of write");
		check_equal(taken, exp_err ? 0 : n, "o_wready pulse count");
		if (!exp_err) begin
			for (int i = 0; i < n; i++) begin
				ref_mem[8'(reg_addr + i)] = wbuf[i];
			end
		end
		compare_memory();
	endtask

	task automatic read_txn(input logic [6:0] dev, input i2c_pkg::byte_t reg_addr,
			input int n, input logic exp_err);
		int got;
		got = 0;
		i_dev_addr = dev;
		i_reg_addr = reg_addr;
		i_rlast = (n == 1);
		i_rd_req = 1'b1;
		@(posedge clk);
		#1;
		i_rd_req = 1'b0;
		check_equal(o_busy, 1'b1, "o_busy after read request");
		check_equal(o_ack_err, 1'b0, "o_ack_err cleared by read request");
		while (o_busy) begin
			@(posedge clk);
			#1;
			check_equal(o_wready, 1'b0, "o_wready during read");
			if (o_rvalid) begin
				check_equal(o_rdata, ref_mem[8'(reg_addr + got)],
					$sformatf("read byte %0d from register %02h", got, reg_addr));
				got++;
				i_rlast = (got == n - 1);
			end
		end
		check_equal(o_ack_err, exp_err, "o_ack_err at end of read");
		check_equal(got, exp_err ? 0 : n, "o_rvalid pulse count");
		check_equal(rd_acks, exp_err ? 0 : n - 1, "ACKs seen by slave");
		check_equal(rd_nacks, exp_err ? 0 : 1, "NACKs seen by slave");
		compare_memory();
	endtask

	task automatic random_write(output i2c_pkg::byte_t reg_addr, output int n);
		reg_addr = i2c_pkg::byte_t'(rand_below(256));
		n = 1 + rand_below(6);
		for (int i = 0; i < n; i++) begin
			wbuf[i] = i2c_pkg::byte_t'(rand_below(256));
		end
		write_txn(SLAVE_ADDR, reg_addr, n, 1'b0);
	endtask

	initial begin
		i2c_pkg::byte_t reg_addr;
		int n;
		i_wr_req = 1'b0;
		i_rd_req = 1'b0;
		i_dev_addr = '0;
		i_reg_addr = '0;
		i_wdata = '0;
		i_wlast = 1'b0;
		i_rlast = 1'b0;
		rng_state = 32'd23991;
		for (int a = 0; a < 256; a++) begin
			ref_mem[a] = fill_byte(a);
			u_slave_bfm.mem[a] = fill_byte(a);
		end
		@(posedge rstn);
		@(posedge clk);
		#1;
		check_equal(o_busy, 1'b0, "o_busy after reset");
		check_equal(o_ack_err, 1'b0, "o_ack_err after reset");
		check_equal(o_wready, 1'b0, "o_wready after reset");
		check_equal(o_rvalid, 1'b0, "o_rvalid after reset");
		check_equal(o_scl, 1'b1, "o_scl after reset");
		check_equal(o_sda, 1'b1, "o_sda after reset");
		check_equal(o_sda_oe, 1'b0, "o_sda_oe after reset");

		repeat (3) begin
			random_write(reg_addr, n);
		end
		repeat (3) begin
			read_txn(SLAVE_ADDR, i2c_pkg::byte_t'(rand_below(256)), 1 + rand_below(6), 1'b0);
		end

		// Nobody answers this address
		n = 1 + rand_below(6);
		for (int i = 0; i < n; i++) begin
			wbuf[i] = i2c_pkg::byte_t'(rand_below(256));
		end
		write_txn(BAD_ADDR, i2c_pkg::byte_t'(rand_below(256)), n, 1'b1);
		read_txn(BAD_ADDR, i2c_pkg::byte_t'(rand_below(256)), 1 + rand_below(6), 1'b1);

		// Read back what was just written
		repeat (2) begin
			random_write(reg_addr, n);
			read_txn(SLAVE_ADDR, reg_addr, n, 1'b0);
		end

		$display("test passed");
		$finish;
	end

endmodule

// ==== tb.f ====
hdl/i2c_pkg.sv
hdl/i2c_scl_gen.sv
hdl/i2c_byte_tx.sv
hdl/i2c_byte_rx.sv
hdl/i2c_txn_ctrl.sv
hdl/i2c_master.sv
dv/tb_clk_gen.sv
dv/i2c_slave_bfm.sv
dv/tb_i2c_master.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - files:
      - hdl/i2c_pkg.sv
      - hdl/i2c_scl_gen.sv
      - hdl/i2c_byte_tx.sv
      - hdl/i2c_byte_rx.sv
      - hdl/i2c_txn_ctrl.sv
      - hdl/i2c_master.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/i2c_slave_bfm.sv
      - dv/tb_i2c_master.sv
